// File: verilog/fc_macros.svh
`ifndef FC_MACROS_SVH
`define FC_MACROS_SVH

// Operand byte and lanes per output group
`define FC_DATA_W 8
`define FC_LANES 4

// Accumulator and layer counter widths
`define FC_ACC_W 28
`define FC_LEN_W 10
`define FC_GRP_W 6

// Multiplier register stages ahead of the accumulator
`define FC_MUL_STAGES 4

// Requantization to a 7-bit activation
`define FC_QSHIFT 6
`define FC_QMAX 127

`endif

// File: verilog/fc_pkg.sv
`default_nettype none

`include "fc_macros.svh"

package fc_pkg;

  // Output index, group number times lane count plus lane
  typedef logic [7:0] idx_t;

  // One streamed element, lane 0 weight in the low byte
  typedef struct packed {
    logic signed [`FC_DATA_W-1:0]         feat;
    logic [`FC_LANES-1:0][`FC_DATA_W-1:0] weight;
  } elem_t;

  typedef struct packed {
    logic [`FC_LANES-1:0][`FC_DATA_W-1:0] lane;
  } act_vec_t;

  // Each lane byte is read as signed
  typedef struct packed {
    logic [`FC_LANES-1:0][`FC_DATA_W-1:0] lane;
  } bias_vec_t;

  typedef struct packed {
    logic [`FC_LEN_W-1:0] vec_len;
    logic [`FC_GRP_W-1:0] groups;
    bias_vec_t            bias;
  } cfg_t;

  typedef enum logic [1:0] {
    CFG_LEN    = 2'd0,
    CFG_GROUPS = 2'd1,
    CFG_BIAS   = 2'd2
  } cfg_addr_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ACCUM,
    ST_DRAIN,
    ST_EMIT,
    ST_DONE
  } fc_state_e;

endpackage

`default_nettype wire

// File: verilog/fc_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_macros.svh"

module fc_cfg_regs (
  input  logic              clk,
  input  logic              rstn,
  input  logic              cfg_we,
  input  fc_pkg::cfg_addr_e cfg_addr,
  input  logic [31:0]       cfg_wdata,
  output fc_pkg::cfg_t      cfg
);
  import fc_pkg::*;

  logic len_we;
  logic grp_we;
  logic bias_we;

  // Address decode
  assign len_we  = cfg_we && (cfg_addr == CFG_LEN);
  assign grp_we  = cfg_we && (cfg_addr == CFG_GROUPS);
  assign bias_we = cfg_we && (cfg_addr == CFG_BIAS);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg <= '0;
    end else begin
      if (len_we) begin
        cfg.vec_len <= cfg_wdata[`FC_LEN_W-1:0];
      end
      if (grp_we) begin
        cfg.groups <= cfg_wdata[`FC_GRP_W-1:0];
      end
      // All four biases of the coming group at once
      if (bias_we) begin
        cfg.bias <= bias_vec_t'(cfg_wdata);
      end
    end
  end

  // A zero length would never close a group
  a_len_nonzero: assert property (
    @(posedge clk) disable iff (!rstn)
    len_we |=> (cfg.vec_len != '0)
  ) else $error("vector length written as zero");

endmodule

`default_nettype wire

// File: verilog/fc_mac_pe.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_macros.svh"

module fc_mac_pe (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        elem_valid,
  input  logic                        elem_first,
  input  logic signed [`FC_DATA_W-1:0] feat,
  input  logic signed [`FC_DATA_W-1:0] weight,
  output logic signed [`FC_ACC_W-1:0]  acc
);
  localparam int DW = `FC_DATA_W;
  localparam int PW = 2 * `FC_DATA_W;

  logic [DW-1:0]             feat_mag;
  logic [DW-1:0]             wgt_mag;
  logic [DW-1:0][DW-1:0]     pp;
  logic [DW-1:0][DW-1:0]     pp_q;
  logic [DW/2-1:0][DW+1:0]   sum2;
  logic [DW/2-1:0][DW+1:0]   sum2_q;
  logic [DW/4-1:0][DW+3:0]   sum3;
  logic [PW-1:0]             mag;
  logic [PW-1:0]             mag_q;
  logic signed [PW-1:0]      prod_q;
  logic signed [`FC_ACC_W-1:0] prod_ext;
  logic v1, v2, v3, v4;
  logic f1, f2, f3, f4;
  logic s1, s2, s3;

  ////////////////////
  // Stage 1 magnitudes and partial products
  assign feat_mag = feat[DW-1] ? (~feat + 1'b1) : feat;
  assign wgt_mag  = weight[DW-1] ? (~weight + 1'b1) : weight;

  always_comb begin
    for (int i = 0; i < DW; i++) begin
      pp[i] = wgt_mag[i] ? feat_mag : '0;
    end
  end

  ////////////////////
  // Stages 2 and 3, pairwise adder tree
  always_comb begin
    for (int j = 0; j < DW/2; j++) begin
      sum2[j] = pp_q[2*j] + {pp_q[2*j+1], 1'b0};
    end
  end

  always_comb begin
    for (int k = 0; k < DW/4; k++) begin
      sum3[k] = sum2_q[2*k] + {sum2_q[2*k+1], 2'b00};
    end
    mag = sum3[0] + {sum3[1], 4'b0000};
  end

  assign prod_ext = {{(`FC_ACC_W-PW){prod_q[PW-1]}}, prod_q};

  // Valid bits follow each element down the pipe
  always_ff @(posedge clk) begin
    if (!rstn) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
      v3 <= 1'b0;
      v4 <= 1'b0;
    end else begin
      v1 <= elem_valid;
      v2 <= v1;
      v3 <= v2;
      v4 <= v3;
    end
  end

  always_ff @(posedge clk) begin
    if (elem_valid) begin
      pp_q <= pp;
      s1   <= feat[DW-1] ^ weight[DW-1];
      f1   <= elem_first;
    end
    if (v1) begin
      sum2_q <= sum2;
      s2     <= s1;
      f2     <= f1;
    end
    if (v2) begin
      mag_q <= mag;
      s3    <= s2;
      f3    <= f2;
    end
    // Stage 4 puts the sign back
    if (v3) begin
      prod_q <= s3 ? (~mag_q + 1'b1) : mag_q;
      f4     <= f3;
    end
    // First element of a group loads instead of adding
    if (v4) begin
      acc <= f4 ? prod_ext : acc + prod_ext;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fc_requant.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_macros.svh"

module fc_requant (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        emit,
  input  logic signed [`FC_ACC_W-1:0] acc0,
  input  logic signed [`FC_ACC_W-1:0] acc1,
  input  logic signed [`FC_ACC_W-1:0] acc2,
  input  logic signed [`FC_ACC_W-1:0] acc3,
  input  fc_pkg::bias_vec_t           bias,
  output logic                        out_valid,
  output fc_pkg::act_vec_t            out_data
);
  import fc_pkg::*;

  localparam int AW = `FC_ACC_W;
  localparam int DW = `FC_DATA_W;

  logic signed [AW-1:0] acc_lane [`FC_LANES];
  act_vec_t             act;

  // Bias add, then ReLU, shift and clamp
  function automatic logic [DW-1:0] relu_sat(
    input logic signed [AW-1:0] a,
    input logic signed [DW-1:0] b
  );
    logic signed [AW-1:0] sum;
    logic signed [AW-1:0] shifted;
    sum     = a + AW'(b);
    shifted = sum >>> `FC_QSHIFT;
    if (sum < 0) begin
      relu_sat = '0;
    end else if (shifted > `FC_QMAX) begin
      relu_sat = DW'(`FC_QMAX);
    end else begin
      relu_sat = shifted[DW-1:0];
    end
  endfunction

  assign acc_lane[0] = acc0;
  assign acc_lane[1] = acc1;
  assign acc_lane[2] = acc2;
  assign acc_lane[3] = acc3;

  always_comb begin
    for (int i = 0; i < `FC_LANES; i++) begin
      act.lane[i] = relu_sat(acc_lane[i], $signed(bias.lane[i]));
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= emit;
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      out_data <= act;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fc_argmax.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_macros.svh"

module fc_argmax (
  input  logic             clk,
  input  logic             rstn,
  input  logic             clear,
  input  logic             out_valid,
  input  fc_pkg::act_vec_t out_data,
  input  fc_pkg::idx_t     group_base,
  output fc_pkg::idx_t     max_idx
);
  import fc_pkg::*;

  logic [`FC_DATA_W-1:0] best_val;
  logic [`FC_DATA_W-1:0] scan_val;
  logic                  seen;
  logic                  scan_seen;
  idx_t                  scan_idx;

  // Lane 0 first, strictly greater wins so a tie keeps the lower index
  always_comb begin
    scan_val  = best_val;
    scan_idx  = max_idx;
    scan_seen = seen;
    for (int i = 0; i < `FC_LANES; i++) begin
      if (!scan_seen || (out_data.lane[i] > scan_val)) begin
        scan_val  = out_data.lane[i];
        scan_idx  = group_base + idx_t'(i);
        scan_seen = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn || clear) begin
      seen    <= 1'b0;
      max_idx <= '0;
    end else if (out_valid) begin
      seen     <= 1'b1;
      best_val <= scan_val;
      max_idx  <= scan_idx;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_macros.svh"

module fc_ctrl (
  input  logic         clk,
  input  logic         rstn,
  input  fc_pkg::cfg_t cfg,
  input  logic         start,
  input  logic         in_valid,
  output logic         elem_valid,
  output logic         elem_first,
  output logic         emit,
  output fc_pkg::idx_t group_base,
  output logic         clear,
  output logic         layer_done
);
  import fc_pkg::*;

  localparam int DRAIN_W = $clog2(`FC_MUL_STAGES);

  fc_state_e            state;
  logic [`FC_LEN_W-1:0] elem_cnt;
  logic [`FC_LEN_W-1:0] elem_nxt;
  logic [DRAIN_W-1:0]   drain_cnt;
  logic [`FC_GRP_W-1:0] grp_cnt;
  logic [`FC_GRP_W-1:0] grp_nxt;
  logic                 last_elem;
  logic                 last_grp;

  assign elem_nxt  = elem_cnt + 1'b1;
  assign grp_nxt   = grp_cnt + 1'b1;
  assign last_elem = (elem_nxt == cfg.vec_len);
  assign last_grp  = (grp_nxt == cfg.groups);

  assign elem_valid = in_valid && (state == ST_ACCUM);
  assign elem_first = elem_valid && (elem_cnt == '0);
  assign emit       = (state == ST_EMIT);
  assign clear      = start && (state == ST_IDLE);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= ST_IDLE;
      elem_cnt   <= '0;
      drain_cnt  <= '0;
      grp_cnt    <= '0;
      group_base <= '0;
      layer_done <= 1'b0;
    end else begin
      layer_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            elem_cnt <= '0;
            grp_cnt  <= '0;
            state    <= ST_ACCUM;
          end
        end
        ST_ACCUM: begin
          if (in_valid && last_elem) begin
            elem_cnt  <= '0;
            drain_cnt <= '0;
            state     <= ST_DRAIN;
          end else if (in_valid) begin
            elem_cnt <= elem_nxt;
          end
        end
        // Let the last product reach the accumulators
        ST_DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == DRAIN_W'(`FC_MUL_STAGES - 1)) begin
            state <= ST_EMIT;
          end
        end
        ST_EMIT: begin
          // Held for argmax while this group's output is valid
          group_base <= {grp_cnt, 2'b00};
          grp_cnt    <= grp_nxt;
          state      <= last_grp ? ST_DONE : ST_ACCUM;
        end
        ST_DONE: begin
          layer_done <= 1'b1;
          state      <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  a_in_valid_accum: assert property (
    @(posedge clk) disable iff (!rstn)
    in_valid |-> (state == ST_ACCUM)
  ) else $error("element strobe outside ACCUM");

endmodule

`default_nettype wire

// File: verilog/fc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_macros.svh"

module fc_top (
  input  logic              clk,
  input  logic              rstn,
  input  logic              cfg_we,
  input  fc_pkg::cfg_addr_e cfg_addr,
  input  logic [31:0]       cfg_wdata,
  input  logic              start,
  input  logic              in_valid,
  input  fc_pkg::elem_t     in_elem,
  output logic              out_valid,
  output fc_pkg::act_vec_t  out_data,
  output logic              layer_done,
  output fc_pkg::idx_t      max_idx
);
  import fc_pkg::*;

  cfg_t                        cfg;
  logic                        elem_valid;
  logic                        elem_first;
  logic                        emit;
  logic                        clear;
  idx_t                        group_base;
  logic signed [`FC_ACC_W-1:0] acc [`FC_LANES];

  fc_cfg_regs cfg_regs_i (
    .clk       (clk),
    .rstn      (rstn),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  fc_ctrl ctrl_i (
    .clk        (clk),
    .rstn       (rstn),
    .cfg        (cfg),
    .start      (start),
    .in_valid   (in_valid),
    .elem_valid (elem_valid),
    .elem_first (elem_first),
    .emit       (emit),
    .group_base (group_base),
    .clear      (clear),
    .layer_done (layer_done)
  );

  ////////////////////
  // Lanes share the feature byte
  for (genvar g = 0; g < `FC_LANES; g++) begin : g_lane
    fc_mac_pe pe_i (
      .clk        (clk),
      .rstn       (rstn),
      .elem_valid (elem_valid),
      .elem_first (elem_first),
      .feat       (in_elem.feat),
      .weight     (in_elem.weight[g]),
      .acc        (acc[g])
    );
  end

  fc_requant requant_i (
    .clk       (clk),
    .rstn      (rstn),
    .emit      (emit),
    .acc0      (acc[0]),
    .acc1      (acc[1]),
    .acc2      (acc[2]),
    .acc3      (acc[3]),
    .bias      (cfg.bias),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  fc_argmax argmax_i (
    .clk        (clk),
    .rstn       (rstn),
    .clear      (clear),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .group_base (group_base),
    .max_idx    (max_idx)
  );

endmodule

`default_nettype wire

// File: verif/fc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_macros.svh"

module fc_tb;
  import fc_pkg::*;

  // Test 4 may add up to two idle cycles after every element
  localparam int TOTAL_ELEMS  = 48;
  localparam int TOTAL_GROUPS = 9;
  localparam int CYCLE_LIMIT  = 3 * TOTAL_ELEMS + 16 * TOTAL_GROUPS + 200;

  logic        clk;
  logic        rstn;
  logic        cfg_we;
  cfg_addr_e   cfg_addr;
  logic [31:0] cfg_wdata;
  logic        start;
  logic        in_valid;
  elem_t       in_elem;
  logic        out_valid;
  act_vec_t    out_data;
  logic        layer_done;
  idx_t        max_idx;

  // Reference model operands and expected results
  logic signed [`FC_DATA_W-1:0] feat_a [64];
  logic signed [`FC_DATA_W-1:0] wgt_a [64][`FC_LANES];
  logic signed [`FC_DATA_W-1:0] bias_a [`FC_LANES];
  act_vec_t                     exp_data;
  idx_t                         exp_idx;
  logic [`FC_DATA_W-1:0]        best_val;
  logic                         best_seen;
  logic                         last_drv;
  logic                         last_grp;
  logic                         idle_chk;
  logic [31:0]                  lcg_state;
  int                           err_cnt;
  int                           err_mark;
  int                           test_cnt;
  int                           out_cnt = 0;
  int                           cyc = 0;

  fc_top dut_i (
    .clk        (clk),
    .rstn       (rstn),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .start      (start),
    .in_valid   (in_valid),
    .in_elem    (in_elem),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .layer_done (layer_done),
    .max_idx    (max_idx)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (out_valid) begin
      out_cnt <= out_cnt + 1;
    end
    if (cyc == CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, an expected strobe never came", cyc);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////
  // Checks

  a_quiet: assert property (@(posedge clk) disable iff (!rstn)
    idle_chk |-> !out_valid && !layer_done)
    else begin
      $display("output strobe raised before any layer was started");
      err_cnt++;
    end

  a_out_data: assert property (@(posedge clk) disable iff (!rstn)
    out_valid |-> out_data == exp_data)
    else begin
      $display("FAIL out_data got %h exp %h", $sampled(out_data), $sampled(exp_data));
      err_cnt++;
    end

  // Six cycles from the edge that samples the last element
  a_out_timing: assert property (@(posedge clk) disable iff (!rstn)
    in_valid && last_drv |-> !out_valid [*6] ##1 out_valid)
    else begin
      $display("out_valid did not pulse exactly six cycles after the last element");
      err_cnt++;
    end

  a_out_pulse: assert property (@(posedge clk) disable iff (!rstn)
    out_valid |=> !out_valid)
    else begin
      $display("out_valid stayed high for more than one cycle");
      err_cnt++;
    end

  a_done_timing: assert property (@(posedge clk) disable iff (!rstn)
    out_valid && last_grp |=> layer_done)
    else begin
      $display("layer_done missing the cycle after the last group output");
      err_cnt++;
    end

  a_done_only: assert property (@(posedge clk) disable iff (!rstn)
    layer_done |-> $past(out_valid) && last_grp)
    else begin
      $display("layer_done raised without a last group output before it");
      err_cnt++;
    end

  a_max_idx: assert property (@(posedge clk) disable iff (!rstn)
    layer_done |-> max_idx == exp_idx)
    else begin
      $display("FAIL max_idx got %h exp %h", $sampled(max_idx), $sampled(exp_idx));
      err_cnt++;
    end

  ////////////////////
  // Stimulus and model helpers

  function automatic logic [7:0] lcg_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  // Signed dot product plus bias, then ReLU, shift and clamp
  function automatic logic [7:0] model_lane(input int len, input int lane);
    int sum;
    int q;
    sum = int'(bias_a[lane]);
    for (int k = 0; k < len; k++) begin
      sum += int'(feat_a[k]) * int'(wgt_a[k][lane]);
    end
    if (sum < 0) begin
      return 8'd0;
    end
    q = sum >>> `FC_QSHIFT;
    if (q > `FC_QMAX) begin
      return 8'(`FC_QMAX);
    end
    return 8'(q);
  endfunction

  task automatic set_elem(input int k, input int f, input int w0, input int w1,
                          input int w2, input int w3);
    feat_a[k]    = 8'(f);
    wgt_a[k][0]  = 8'(w0);
    wgt_a[k][1]  = 8'(w1);
    wgt_a[k][2]  = 8'(w2);
    wgt_a[k][3]  = 8'(w3);
  endtask

  task automatic set_bias(input int b0, input int b1, input int b2, input int b3);
    bias_a[0] = 8'(b0);
    bias_a[1] = 8'(b1);
    bias_a[2] = 8'(b2);
    bias_a[3] = 8'(b3);
  endtask

  // Narrow features keep most random sums inside the activation range
  task automatic random_group(input int len);
    for (int k = 0; k < len; k++) begin
      feat_a[k] = $signed(lcg_byte()) >>> 2;
      for (int l = 0; l < `FC_LANES; l++) begin
        wgt_a[k][l] = lcg_byte();
      end
    end
    for (int l = 0; l < `FC_LANES; l++) begin
      bias_a[l] = lcg_byte();
    end
  endtask

  task automatic write_cfg(input cfg_addr_e addr, input logic [31:0] data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  // Start shares a cycle with the length write and the group count follows.
  // Called on a falling edge so start goes out in the very next cycle
  task automatic begin_layer(input int len, input int groups);
    idle_chk  = 1'b0;
    start     = 1'b1;
    cfg_we    = 1'b1;
    cfg_addr  = CFG_LEN;
    cfg_wdata = 32'(len);
    @(negedge clk);
    start     = 1'b0;
    cfg_addr  = CFG_GROUPS;
    cfg_wdata = 32'(groups);
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic send_group(input int len, input int grp, input bit gaps, input bit last);
    act_vec_t exp_v;
    int       n_gap;
    write_cfg(CFG_BIAS, {bias_a[3], bias_a[2], bias_a[1], bias_a[0]});
    if (grp == 0) begin
      best_seen = 1'b0;
    end
    // Lowest index wins a tie
    for (int l = 0; l < `FC_LANES; l++) begin
      exp_v.lane[l] = model_lane(len, l);
      if (!best_seen || exp_v.lane[l] > best_val) begin
        best_val  = exp_v.lane[l];
        exp_idx   = idx_t'(grp * `FC_LANES + l);
        best_seen = 1'b1;
      end
    end
    exp_data = exp_v;
    last_grp = last;
    for (int k = 0; k < len; k++) begin
      @(negedge clk);
      in_valid     = 1'b1;
      in_elem.feat = feat_a[k];
      for (int l = 0; l < `FC_LANES; l++) begin
        in_elem.weight[l] = wgt_a[k][l];
      end
      last_drv = (k == len - 1);
      if (gaps && k < len - 1) begin
        n_gap = int'(lcg_byte() % 3);
        repeat (n_gap) begin
          @(negedge clk);
          in_valid = 1'b0;
        end
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    last_drv = 1'b0;
    do begin
      @(negedge clk);
    end while (out_valid !== 1'b1);
    @(negedge clk);
  endtask

  task automatic finish_layer();
    while (layer_done !== 1'b1) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic report_test(input int num, input string name);
    test_cnt++;
    if (err_cnt == err_mark) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  ////////////////////
  // Test sequence

  initial begin
    rstn      = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = CFG_LEN;
    cfg_wdata = '0;
    start     = 1'b0;
    in_valid  = 1'b0;
    in_elem   = '0;
    last_drv  = 1'b0;
    last_grp  = 1'b0;
    idle_chk  = 1'b1;
    exp_data  = '0;
    exp_idx   = '0;
    best_val  = '0;
    best_seen = 1'b0;
    lcg_state = 32'h206c;
    err_cnt   = 0;
    err_mark  = 0;
    test_cnt  = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    repeat (10) @(negedge clk);
    report_test(1, "reset quiet");

    // Extreme operands in lanes 0 and 1
    set_elem(0, 127, 127, -128, 10, 1);
    set_elem(1, -128, -128, 127, -7, 2);
    set_elem(2, 50, 3, 60, 100, -20);
    set_elem(3, -3, -1, 2, 5, 9);
    set_bias(3, 0, 10, -5);
    begin_layer(4, 1);
    send_group(4, 0, 1'b0, 1'b1);
    finish_layer();
    report_test(2, "hand picked group");

    for (int k = 0; k < 4; k++) begin
      set_elem(k, 127, 127, -128, 1, -1);
    end
    set_bias(0, 0, 20, 127);
    begin_layer(4, 1);
    send_group(4, 0, 1'b0, 1'b1);
    finish_layer();
    report_test(3, "relu and saturation");

    begin_layer(6, 3);
    for (int g = 0; g < 3; g++) begin
      random_group(6);
      send_group(6, g, 1'b1, g == 2);
    end
    finish_layer();
    report_test(4, "random three groups");

    // Lanes 1 and 2 tie in group 0 and lanes 4 and 6 match them in group 1
    set_bias(0, 0, 0, 0);
    begin_layer(2, 2);
    set_elem(0, 64, 5, 20, 20, 2);
    set_elem(1, 64, 5, 20, 20, 3);
    send_group(2, 0, 1'b0, 1'b0);
    set_elem(0, 64, 20, 1, 20, 1);
    set_elem(1, 64, 20, 1, 20, 2);
    send_group(2, 1, 1'b0, 1'b1);
    finish_layer();
    report_test(5, "argmax with tie");

    begin_layer(9, 2);
    for (int g = 0; g < 2; g++) begin
      random_group(9);
      send_group(9, g, 1'b0, g == 1);
    end
    finish_layer();
    report_test(6, "second layer");

    repeat (4) @(negedge clk);
    if (out_cnt != TOTAL_GROUPS) begin
      $display("saw %0d group outputs where %0d were expected", out_cnt, TOTAL_GROUPS);
      err_cnt++;
    end
    $display("tests %0d, outputs %0d, errors %0d", test_cnt, out_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verilog
verilog/fc_pkg.sv
verilog/fc_cfg_regs.sv
verilog/fc_mac_pe.sv
verilog/fc_requant.sv
verilog/fc_argmax.sv
verilog/fc_ctrl.sv
verilog/fc_top.sv
verif/fc_tb.sv

// File: Bender.yml
package:
  name: fc_engine

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fc_pkg.sv
      - verilog/fc_cfg_regs.sv
      - verilog/fc_mac_pe.sv
      - verilog/fc_requant.sv
      - verilog/fc_argmax.sv
      - verilog/fc_ctrl.sv
      - verilog/fc_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/fc_tb.sv
